/* cnn_pkg.sv */
// Sizes, derived widths, Wishbone register map and line-buffer state type for the 3x3 conv layer
package cnn_pkg;

    // Frame geometry
    localparam int IMG_WIDTH = 8;
    localparam int IMG_HEIGHT = 8;
    localparam int KERNEL_SIZE = 3;

    // Number formats
    localparam int VALUE_BITS = 8;
    localparam int WEIGHT_BITS = 8;
    localparam int WEIGHT_Q_SHIFT = 6;
    localparam int NUM_WEIGHTS = KERNEL_SIZE * KERNEL_SIZE;

    // Averaging kernel, 64 / 9 truncates to 7
    localparam int WEIGHT_RESET = (1 << WEIGHT_Q_SHIFT) / NUM_WEIGHTS;

    // Sum of the nine shifted products, only the low byte leaves the MAC
    localparam int ACC_BITS = 12;
    localparam int PROD_BITS = VALUE_BITS + WEIGHT_BITS;

    // Flat vectors between the stages, element k at bits k*8 upward
    localparam int WIN_BITS = NUM_WEIGHTS * VALUE_BITS;
    localparam int WEIGHTS_BITS = NUM_WEIGHTS * WEIGHT_BITS;

    // Position counters in the line buffer
    localparam int COL_BITS = $clog2(IMG_WIDTH);
    localparam int ROW_BITS = $clog2(IMG_HEIGHT);

    // Wishbone classic weight port
    localparam int WB_ADDR_BITS = 4;
    localparam int WB_DATA_BITS = 32;

    // Register map: weight row*3+col at word address row*3+col
    localparam int WB_ADDR_WEIGHT_FIRST = 0;
    localparam int WB_ADDR_WEIGHT_LAST = NUM_WEIGHTS - 1;

    // Line buffer modes
    typedef enum logic {
        // Rows 0 and 1 arriving, no complete window yet
        LB_FILL,
        // Row 2 onward, windows leave once the column reaches 2
        LB_RUN
    } lb_state_e;

endpackage

/* cnn_weight_regs.sv */
// Wishbone classic slave holding the nine kernel weights with read-back
`timescale 1ns/1ps

module cnn_weight_regs (
    input  logic                              clock_i,
    input  logic                              reset_i,
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [cnn_pkg::WB_ADDR_BITS-1:0]  wb_adr_i,
    input  logic [cnn_pkg::WB_DATA_BITS-1:0]  wb_dat_i,
    output logic [cnn_pkg::WB_DATA_BITS-1:0]  wb_dat_o,
    output logic                              wb_ack_o,
    output logic [cnn_pkg::WEIGHTS_BITS-1:0]  weights_o
);
    import cnn_pkg::*;

    logic [WEIGHT_BITS-1:0] weight_q [NUM_WEIGHTS];
    logic                   req;
    logic                   hit;

    // New request only while ack is low, so each access gets one ack cycle
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;
    // Weights start at word 0, so only the upper bound decodes
    assign hit = (wb_adr_i <= WB_ADDR_BITS'(WB_ADDR_WEIGHT_LAST));

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
            for (int k = 0; k < NUM_WEIGHTS; k++) begin
                weight_q[k] <= WEIGHT_BITS'(WEIGHT_RESET);
            end
        end else begin
            wb_ack_o <= req;
            // Write lands on the ack edge, unmapped addresses are ignored
            if (req && wb_we_i && hit) begin
                weight_q[wb_adr_i] <= wb_dat_i[WEIGHT_BITS-1:0];
            end
        end
    end

    // Read data captured with the ack, upper bits and holes read zero
    always_ff @(posedge clock_i) begin
        if (req) begin
            if (hit) begin
                wb_dat_o <= WB_DATA_BITS'(weight_q[wb_adr_i]);
            end else begin
                wb_dat_o <= '0;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_WEIGHTS; k++) begin
            weights_o[k*WEIGHT_BITS +: WEIGHT_BITS] = weight_q[k];
        end
    end

endmodule

/* cnn_line_buffer.sv */
// Pixel intake, two row memories and the 3x3 window register with row/column counters
`timescale 1ns/1ps

module cnn_line_buffer (
    input  logic                            clock_i,
    input  logic                            reset_i,
    input  logic [cnn_pkg::VALUE_BITS-1:0]  pix_data_i,
    input  logic                            pix_valid_i,
    input  logic                            advance_i,
    output logic [cnn_pkg::WIN_BITS-1:0]    win_o,
    output logic                            win_valid_o,
    output logic                            win_last_o
);
    import cnn_pkg::*;

    // Rows r-2 and r-1 at every column, indexed by the current column
    logic [VALUE_BITS-1:0] top_mem [IMG_WIDTH];
    logic [VALUE_BITS-1:0] mid_mem [IMG_WIDTH];

    // Window, [row][col] with col 2 the newest column
    logic [VALUE_BITS-1:0] win_q [KERNEL_SIZE][KERNEL_SIZE];
    logic [VALUE_BITS-1:0] new_col [KERNEL_SIZE];

    lb_state_e           state_q;
    logic [COL_BITS-1:0] col_q;
    logic [ROW_BITS-1:0] row_q;
    logic                accept;
    logic                row_end;
    logic                frame_end;
    logic                win_complete;

    assign accept = pix_valid_i && advance_i;
    assign row_end = (col_q == COL_BITS'(IMG_WIDTH - 1));
    assign frame_end = row_end && (row_q == ROW_BITS'(IMG_HEIGHT - 1));
    assign win_complete = (state_q == LB_RUN) && (col_q >= COL_BITS'(KERNEL_SIZE - 1));

    // Column entering the window, oldest row on top
    assign new_col[0] = top_mem[col_q];
    assign new_col[1] = mid_mem[col_q];
    assign new_col[2] = pix_data_i;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= LB_FILL;
            col_q <= '0;
            row_q <= '0;
            win_valid_o <= 1'b0;
            win_last_o <= 1'b0;
        end else if (advance_i) begin
            // Cycles without a pixel push a bubble down the pipeline
            win_valid_o <= accept && win_complete;
            win_last_o <= accept && frame_end;
            if (accept) begin
                if (frame_end) begin
                    col_q <= '0;
                    row_q <= '0;
                    state_q <= LB_FILL;
                end else if (row_end) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                    // Row 1 done, from row 2 on the memories hold full context
                    if (row_q == ROW_BITS'(KERNEL_SIZE - 2)) begin
                        state_q <= LB_RUN;
                    end
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (accept) begin
            top_mem[col_q] <= mid_mem[col_q];
            mid_mem[col_q] <= pix_data_i;
            for (int i = 0; i < KERNEL_SIZE; i++) begin
                for (int j = 0; j < KERNEL_SIZE - 1; j++) begin
                    win_q[i][j] <= win_q[i][j+1];
                end
                win_q[i][KERNEL_SIZE-1] <= new_col[i];
            end
        end
    end

    // Pixel row*3+col goes to the same slot as its weight
    always_comb begin
        for (int i = 0; i < KERNEL_SIZE; i++) begin
            for (int j = 0; j < KERNEL_SIZE; j++) begin
                win_o[(i*KERNEL_SIZE + j)*VALUE_BITS +: VALUE_BITS] = win_q[i][j];
            end
        end
    end

endmodule

/* cnn_conv_kernel.sv */
// Registered fixed-point multiply-accumulate over one 3x3 window
`timescale 1ns/1ps

module cnn_conv_kernel (
    input  logic                              clock_i,
    input  logic                              reset_i,
    input  logic [cnn_pkg::WIN_BITS-1:0]      win_i,
    input  logic                              win_valid_i,
    input  logic                              win_last_i,
    input  logic [cnn_pkg::WEIGHTS_BITS-1:0]  weights_i,
    input  logic                              advance_i,
    output logic [cnn_pkg::VALUE_BITS-1:0]    conv_data_o,
    output logic                              conv_valid_o,
    output logic                              conv_last_o
);
    import cnn_pkg::*;

    logic [PROD_BITS-1:0] prod;
    logic [ACC_BITS-1:0]  acc;

    // Each product drops its fraction bits before it joins the sum
    always_comb begin
        acc = '0;
        for (int k = 0; k < NUM_WEIGHTS; k++) begin
            prod = PROD_BITS'(win_i[k*VALUE_BITS +: VALUE_BITS])
                 * PROD_BITS'(weights_i[k*WEIGHT_BITS +: WEIGHT_BITS]);
            acc = acc + ACC_BITS'(prod >> WEIGHT_Q_SHIFT);
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            conv_valid_o <= 1'b0;
            conv_last_o <= 1'b0;
        end else if (advance_i) begin
            conv_valid_o <= win_valid_i;
            conv_last_o <= win_last_i;
        end
    end

    // Result wraps to the low byte
    always_ff @(posedge clock_i) begin
        if (advance_i) begin
            conv_data_o <= acc[VALUE_BITS-1:0];
        end
    end

endmodule

/* cnn_result_stream.sv */
// Output register for the result stream with valid, last and stall handling
`timescale 1ns/1ps

module cnn_result_stream (
    input  logic                            clock_i,
    input  logic                            reset_i,
    input  logic [cnn_pkg::VALUE_BITS-1:0]  conv_data_i,
    input  logic                            conv_valid_i,
    input  logic                            conv_last_i,
    input  logic                            res_stall_i,
    output logic [cnn_pkg::VALUE_BITS-1:0]  res_data_o,
    output logic                            res_valid_o,
    output logic                            res_last_o,
    output logic                            advance_o
);

    // Pipeline moves when the output slot is free or being taken this cycle
    assign advance_o = !res_valid_o || !res_stall_i;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            res_valid_o <= 1'b0;
            res_last_o <= 1'b0;
        end else if (advance_o) begin
            // Bubbles load too and simply leave valid low
            res_valid_o <= conv_valid_i;
            res_last_o <= conv_last_i;
        end
    end

    // Held while stalled so the sink sees stable data
    always_ff @(posedge clock_i) begin
        if (advance_o) begin
            res_data_o <= conv_data_i;
        end
    end

endmodule

/* cnn_layer_top.sv */
// Top level of the conv layer: weight registers, line buffer, MAC and result stage
`timescale 1ns/1ps

module cnn_layer_top (
    input  logic                              clock_i,
    input  logic                              reset_i,
    // Pixel stream
    input  logic [cnn_pkg::VALUE_BITS-1:0]    pix_data_i,
    input  logic                              pix_valid_i,
    output logic                              pix_stall_o,
    // Result stream
    output logic [cnn_pkg::VALUE_BITS-1:0]    res_data_o,
    output logic                              res_valid_o,
    output logic                              res_last_o,
    input  logic                              res_stall_i,
    // Weight port
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [cnn_pkg::WB_ADDR_BITS-1:0]  wb_adr_i,
    input  logic [cnn_pkg::WB_DATA_BITS-1:0]  wb_dat_i,
    output logic [cnn_pkg::WB_DATA_BITS-1:0]  wb_dat_o,
    output logic                              wb_ack_o
);
    import cnn_pkg::*;

    logic [WEIGHTS_BITS-1:0] weights;
    logic [WIN_BITS-1:0]     win;
    logic                    win_valid;
    logic                    win_last;
    logic [VALUE_BITS-1:0]   conv_data;
    logic                    conv_valid;
    logic                    conv_last;
    logic                    advance;

    // One advance for every stage, the source stalls with the rest
    assign pix_stall_o = !advance;

    cnn_weight_regs weight_regs0 (
        .clock_i(clock_i), .reset_i(reset_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .weights_o(weights)
    );

    // Decode: window formation
    cnn_line_buffer line_buffer0 (
        .clock_i(clock_i), .reset_i(reset_i),
        .pix_data_i(pix_data_i), .pix_valid_i(pix_valid_i), .advance_i(advance),
        .win_o(win), .win_valid_o(win_valid), .win_last_o(win_last)
    );

    // Execute: MAC
    cnn_conv_kernel conv_kernel0 (
        .clock_i(clock_i), .reset_i(reset_i),
        .win_i(win), .win_valid_i(win_valid), .win_last_i(win_last),
        .weights_i(weights), .advance_i(advance),
        .conv_data_o(conv_data), .conv_valid_o(conv_valid), .conv_last_o(conv_last)
    );

    // Result: output register and back-pressure
    cnn_result_stream result_stream0 (
        .clock_i(clock_i), .reset_i(reset_i),
        .conv_data_i(conv_data), .conv_valid_i(conv_valid), .conv_last_i(conv_last),
        .res_stall_i(res_stall_i),
        .res_data_o(res_data_o), .res_valid_o(res_valid_o), .res_last_o(res_last_o),
        .advance_o(advance)
    );

endmodule

/* cnn_tb_util.svh */
// LFSR step function, result check task and Wishbone master tasks for the testbench
`ifndef CNN_TB_UTIL_SVH
`define CNN_TB_UTIL_SVH

// Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

task automatic check(input string test_name, input int expected, input int actual);
    if (expected != actual) begin
        $display("ERR %s expected %0d actual %0d", test_name, expected, actual);
        $display("Test failures found");
        $fatal(1);
    end
endtask

// One classic cycle on the testbench signals clock, wb_cyc, wb_stb, wb_we,
// wb_adr, wb_wdata, wb_rdata and wb_ack
task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                        output logic [31:0] rdata);
    int cycles;
    cycles = 0;
    @(posedge clock);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= adr;
    wb_wdata <= wdata;
    do begin
        @(posedge clock);
        cycles++;
        if (cycles > 16) begin
            $display("Timeout waiting for Wishbone ack at address %0d", adr);
            $display("Test failures found");
            $fatal(1);
        end
    end while (!wb_ack);
    rdata = wb_rdata;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
endtask

`endif

/* cnn_tb.sv */
// Testbench for the conv layer with clock, reset, random stimulus, reference model and checks
`timescale 1ns/1ps

module cnn_tb;
    import cnn_pkg::*;

    localparam int FRAME_PIXELS = IMG_WIDTH * IMG_HEIGHT;

    logic        clock, reset, pix_valid, pix_stall, res_valid, res_last, res_stall;
    logic        wb_cyc, wb_stb, wb_we, wb_ack, held_valid;
    logic [7:0]  pix_data, res_data, held_data;
    logic [3:0]  wb_adr;
    logic [31:0] wb_wdata, wb_rdata, lfsr, rdata;
    logic [7:0]  weight [NUM_WEIGHTS];
    logic [7:0]  pixel [FRAME_PIXELS];
    int          exp_data_q[$];
    logic        exp_last_q[$];
    string       test_name;

    `include "cnn_tb_util.svh"

    cnn_layer_top dut0 (
        .clock_i(clock), .reset_i(reset),
        .pix_data_i(pix_data), .pix_valid_i(pix_valid), .pix_stall_o(pix_stall),
        .res_data_o(res_data), .res_valid_o(res_valid), .res_last_o(res_last),
        .res_stall_i(res_stall),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_wdata), .wb_dat_o(wb_rdata), .wb_ack_o(wb_ack)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // Valid convolution, each product shifted before the sum, low byte kept
    task automatic fill_frame();
        int sum;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            pixel[i] = 8'(rand_bits(8));
        end
        for (int r = 0; r < IMG_HEIGHT - 2; r++) begin
            for (int c = 0; c < IMG_WIDTH - 2; c++) begin
                sum = 0;
                for (int k = 0; k < NUM_WEIGHTS; k++) begin
                    sum += (int'(pixel[(r + k / 3) * IMG_WIDTH + c + k % 3]) * int'(weight[k]))
                           >> WEIGHT_Q_SHIFT;
                end
                exp_data_q.push_back(sum % 256);
                exp_last_q.push_back(r == IMG_HEIGHT - 3 && c == IMG_WIDTH - 3);
            end
        end
    endtask

    task automatic load_weights();
        for (int k = 0; k < NUM_WEIGHTS; k++) begin
            weight[k] = 8'(rand_bits(8));
            wb_cycle(1'b1, 4'(k), {24'h0, weight[k]}, rdata);
        end
    endtask

    task automatic verify_weights(input string name);
        for (int k = 0; k < NUM_WEIGHTS; k++) begin
            wb_cycle(1'b0, 4'(k), 32'h0, rdata);
            check(name, int'(weight[k]), int'(rdata));
        end
    endtask

    // Source holds a stalled pixel, otherwise picks the next one or a gap
    task automatic stream_frame(input logic gaps, input logic stalls);
        int idx;
        int cycles;
        idx = 0;
        cycles = 0;
        while (idx < FRAME_PIXELS || exp_data_q.size() > 0) begin
            @(posedge clock);
            cycles++;
            if (cycles > 4000) begin
                $display("Timeout waiting for the end of the frame in test %s", test_name);
                $display("Test failures found");
                $fatal(1);
            end
            if (pix_valid && !pix_stall) begin
                idx++;
            end
            res_stall <= stalls && rand_bits(1) != 0;
            if (!(pix_valid && pix_stall)) begin
                pix_valid <= idx < FRAME_PIXELS && !(gaps && rand_bits(2) == 0);
                pix_data <= pixel[idx % FRAME_PIXELS];
            end
        end
        res_stall <= 1'b0;
    endtask

    // Result monitor, in-order compare and stall stability
    always @(posedge clock) begin
        if (reset) begin
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                check("stall_hold_data", int'(held_data), int'(res_data));
                check("stall_hold_valid", 1, int'(res_valid));
            end
            held_valid = res_valid && res_stall;
            held_data = res_data;
            if (res_valid && !res_stall) begin
                if (exp_data_q.size() == 0) begin
                    $display("Result arrived with nothing expected in test %s", test_name);
                    $display("Test failures found");
                    $fatal(1);
                end
                check(test_name, exp_data_q.pop_front(), int'(res_data));
                check({test_name, "_last"}, int'(exp_last_q.pop_front()), int'(res_last));
            end
        end
    end

    initial begin
        lfsr = 32'heea8_691f;
        reset = 1'b1;
        pix_valid = 1'b0;
        pix_data = 8'h0;
        res_stall = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 4'h0;
        wb_wdata = 32'h0;
        test_name = "reset";
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check("reset_res_valid", 0, int'(res_valid));
        check("reset_pix_stall", 0, int'(pix_stall));
        for (int a = 0; a <= NUM_WEIGHTS; a++) begin
            wb_cycle(1'b0, 4'(a), 32'h0, rdata);
            check("reset_weight", a < NUM_WEIGHTS ? WEIGHT_RESET : 0, int'(rdata));
            if (a < NUM_WEIGHTS) begin
                weight[a] = 8'(WEIGHT_RESET);
            end
        end

        test_name = "default_weights";
        fill_frame();
        stream_frame(1'b0, 1'b0);

        test_name = "weight_port";
        load_weights();
        verify_weights("weight_readback");
        wb_cycle(1'b1, 4'd12, 32'hff, rdata);
        verify_weights("unmapped_write");

        test_name = "backpressure";
        fill_frame();
        stream_frame(1'b1, 1'b1);

        // Two frames with new weights between them
        test_name = "frame_a";
        load_weights();
        fill_frame();
        stream_frame(1'b1, 1'b1);
        test_name = "frame_b";
        load_weights();
        fill_frame();
        stream_frame(1'b1, 1'b1);

        // A repeated result would leave the three pipeline registers within this window
        repeat (4) @(posedge clock);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
cnn_pkg.sv
cnn_weight_regs.sv
cnn_line_buffer.sv
cnn_conv_kernel.sv
cnn_result_stream.sv
cnn_layer_top.sv
cnn_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the conv layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module cnn_tb -f list.f -Mdir obj_dir -o cnn_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cnn_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
